/* verilog/pad_pkg.sv */
//======================================
// Controller definitions
// Joystick word layout, LLAPI raw button
// positions and LLAPI type codes
//======================================

package pad_pkg;

	// Player word, MSB first:
	// start select R L Y X B A up down left right
	localparam int JOY_W     = 12;
	localparam int LL_BTN_W  = 32;
	localparam int LL_TYPE_W = 8;

	// Player slots, also the number of USB inputs
	localparam int NUM_SLOTS = 5;

	typedef logic [JOY_W-1:0]     joy_t;
	typedef logic [LL_BTN_W-1:0]  ll_btn_t;
	typedef logic [LL_TYPE_W-1:0] ll_type_t;

	// Type codes meaning no controller attached
	localparam ll_type_t LL_TYPE_NONE    = 8'd0;
	localparam ll_type_t LL_TYPE_INVALID = 8'd255;

	// Saturn family, has no select button
	localparam ll_type_t LL_TYPE_SATURN     = 8'd3;
	localparam ll_type_t LL_TYPE_SATURN_ALT = 8'd8;

	// Raw LLAPI button positions (HID id minus one)
	localparam int LL_B_A0    = 0;
	localparam int LL_B_A1    = 1;
	localparam int LL_B_Y     = 2;
	localparam int LL_B_X     = 3;
	localparam int LL_B_SEL   = 4;
	localparam int LL_B_START = 5;
	localparam int LL_B_L     = 6;
	localparam int LL_B_R     = 7;
	localparam int LL_B_L2    = 8;
	localparam int LL_B_R2    = 9;
	localparam int LL_B_RIGHT = 24;
	localparam int LL_B_LEFT  = 25;
	localparam int LL_B_DOWN  = 26;
	localparam int LL_B_UP    = 27;

endpackage

/* verilog/cfg_pkg.sv */
//======================================
// Router configuration map
// Register addresses and field positions
//======================================

package cfg_pkg;

	localparam int CFG_ADDR_W = 4;
	localparam int CFG_DATA_W = 8;

	//======================================
	// Register addresses
	//======================================

	// LLAPI pads take player slots when set
	localparam logic [CFG_ADDR_W-1:0] ADDR_LLAPI_EN = 4'd0;

	// Exchange players one and two
	localparam logic [CFG_ADDR_W-1:0] ADDR_SWAP = 4'd1;

	// Flag registers use one data bit
	localparam int BIT_FLAG = 0;

endpackage

/* verilog/pad_config.sv */
//======================================
// Router configuration registers
// Strobed writes set the LLAPI enable
// and the player one/two swap
//======================================

module pad_config (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          cfg_wr,
	input  logic [cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  logic [cfg_pkg::CFG_DATA_W-1:0] cfg_data,
	output logic                          llapi_enable,
	output logic                          joy_swap
);

	logic llapi_enable_q;
	logic joy_swap_q;
	logic wr_flag;

	// Only the flag bit of the data is stored
	assign wr_flag = cfg_data[cfg_pkg::BIT_FLAG];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			llapi_enable_q <= 1'b0;
			joy_swap_q     <= 1'b0;
		end else if (cfg_wr) begin
			case (cfg_addr)
				cfg_pkg::ADDR_LLAPI_EN: begin
					llapi_enable_q <= wr_flag;
				end
				cfg_pkg::ADDR_SWAP: begin
					joy_swap_q <= wr_flag;
				end
				default: begin
					// Unmapped address, write dropped
				end
			endcase
		end
	end

	assign llapi_enable = llapi_enable_q;
	assign joy_swap     = joy_swap_q;

endmodule

/* verilog/llapi_port.sv */
//======================================
// LLAPI pad port
// Presence, type based button remap and
// menu combo detection for one pad
//======================================

module llapi_port (
	input  logic              clk_sys,
	input  logic              reset,
	input  pad_pkg::ll_btn_t  buttons,
	input  pad_pkg::ll_type_t pad_type,
	input  logic              link,
	output pad_pkg::joy_t     pad_joy,
	output logic              present,
	output logic              menu_combo
);

	logic          type_valid;
	logic          is_saturn;
	logic          pressed;
	logic          pressed_next;
	logic          combo;
	pad_pkg::joy_t mapped;
	pad_pkg::joy_t pad_joy_q;
	logic          present_q;
	logic          combo_q;

	// Types 0 and 255 report no real controller
	assign type_valid = (pad_type != pad_pkg::LL_TYPE_NONE) &&
		(pad_type != pad_pkg::LL_TYPE_INVALID);

	assign is_saturn = (pad_type == pad_pkg::LL_TYPE_SATURN) ||
		(pad_type == pad_pkg::LL_TYPE_SATURN_ALT);

	//======================================
	// Button remap
	//======================================

	always_comb begin
		mapped = {
			buttons[pad_pkg::LL_B_START], buttons[pad_pkg::LL_B_SEL],
			buttons[pad_pkg::LL_B_R],     buttons[pad_pkg::LL_B_L],
			buttons[pad_pkg::LL_B_Y],     buttons[pad_pkg::LL_B_X],
			buttons[pad_pkg::LL_B_A0],    buttons[pad_pkg::LL_B_A1],
			buttons[pad_pkg::LL_B_UP],    buttons[pad_pkg::LL_B_DOWN],
			buttons[pad_pkg::LL_B_LEFT],  buttons[pad_pkg::LL_B_RIGHT]
		};
		// Saturn: L acts as select, shoulders move to R2/L2
		if (is_saturn) begin
			mapped[10] = buttons[pad_pkg::LL_B_L];
			mapped[9]  = buttons[pad_pkg::LL_B_R2] | buttons[pad_pkg::LL_B_R];
			mapped[8]  = buttons[pad_pkg::LL_B_L2];
		end
	end

	// Down + start + first button, link state not considered
	assign combo = buttons[pad_pkg::LL_B_DOWN] & buttons[pad_pkg::LL_B_START] &
		buttons[pad_pkg::LL_B_A0];

	//======================================
	// Presence
	//======================================

	// Sticky until reset; a press this cycle counts already
	assign pressed_next = pressed | (link & (|buttons));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pressed   <= 1'b0;
			present_q <= 1'b0;
			combo_q   <= 1'b0;
		end else begin
			pressed   <= pressed_next;
			present_q <= link & (type_valid | pressed_next);
			combo_q   <= combo;
		end
	end

	always_ff @(posedge clk_sys) begin
		pad_joy_q <= mapped;
	end

	assign pad_joy    = pad_joy_q;
	assign present    = present_q;
	assign menu_combo = combo_q;

endmodule

/* verilog/slot_allocator.sv */
//======================================
// Player slot allocator
// LLAPI pads take the first slots, USB
// words fill the rest; optional swap
//======================================

module slot_allocator (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          llapi_enable,
	input  logic          joy_swap,
	input  pad_pkg::joy_t joy_a,
	input  logic          present_a,
	input  logic          combo_a,
	input  pad_pkg::joy_t joy_b,
	input  logic          present_b,
	input  logic          combo_b,
	input  pad_pkg::joy_t usb_joy0,
	input  pad_pkg::joy_t usb_joy1,
	input  pad_pkg::joy_t usb_joy2,
	input  pad_pkg::joy_t usb_joy3,
	input  pad_pkg::joy_t usb_joy4,
	output pad_pkg::joy_t joy0,
	output pad_pkg::joy_t joy1,
	output pad_pkg::joy_t joy2,
	output pad_pkg::joy_t joy3,
	output pad_pkg::joy_t joy4,
	output logic          osd_req
);

	logic          use_a;
	logic          use_b;
	logic          osd_q;
	pad_pkg::joy_t usb    [pad_pkg::NUM_SLOTS];
	pad_pkg::joy_t slot   [pad_pkg::NUM_SLOTS];
	pad_pkg::joy_t slot_q [pad_pkg::NUM_SLOTS];

	assign usb   = '{usb_joy0, usb_joy1, usb_joy2, usb_joy3, usb_joy4};
	assign use_a = present_a & llapi_enable;
	assign use_b = present_b & llapi_enable;

	// USB words shift down behind the used pads
	always_comb begin
		if (use_a && use_b) begin
			slot = '{joy_a, joy_b, usb[0], usb[1], usb[2]};
		end else if (use_a || use_b) begin
			slot[0] = use_a ? joy_a : usb[0];
			slot[1] = use_b ? joy_b : usb[0];
			slot[2] = usb[1];
			slot[3] = usb[2];
			slot[4] = usb[3];
		end else begin
			slot = usb;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < pad_pkg::NUM_SLOTS; i++) begin
				slot_q[i] <= '0;
			end
			osd_q <= 1'b0;
		end else begin
			// Swap applies after allocation
			slot_q[0] <= joy_swap ? slot[1] : slot[0];
			slot_q[1] <= joy_swap ? slot[0] : slot[1];
			for (int i = 2; i < pad_pkg::NUM_SLOTS; i++) begin
				slot_q[i] <= slot[i];
			end
			osd_q <= combo_a | combo_b;
		end
	end

	assign joy0    = slot_q[0];
	assign joy1    = slot_q[1];
	assign joy2    = slot_q[2];
	assign joy3    = slot_q[3];
	assign joy4    = slot_q[4];
	assign osd_req = osd_q;

endmodule

/* verilog/pad_router_top.sv */
//======================================
// Controller input router top
// Two LLAPI pads and five USB words to
// five player joystick words
//======================================

module pad_router_top (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           cfg_wr,
	input  logic [cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  logic [cfg_pkg::CFG_DATA_W-1:0] cfg_data,
	input  pad_pkg::ll_btn_t               llapi_buttons_a,
	input  pad_pkg::ll_type_t              llapi_type_a,
	input  logic                           llapi_link_a,
	input  pad_pkg::ll_btn_t               llapi_buttons_b,
	input  pad_pkg::ll_type_t              llapi_type_b,
	input  logic                           llapi_link_b,
	input  pad_pkg::joy_t                  usb_joy0,
	input  pad_pkg::joy_t                  usb_joy1,
	input  pad_pkg::joy_t                  usb_joy2,
	input  pad_pkg::joy_t                  usb_joy3,
	input  pad_pkg::joy_t                  usb_joy4,
	output pad_pkg::joy_t                  joy0,
	output pad_pkg::joy_t                  joy1,
	output pad_pkg::joy_t                  joy2,
	output pad_pkg::joy_t                  joy3,
	output pad_pkg::joy_t                  joy4,
	output logic                           osd_req
);

	logic          llapi_enable;
	logic          joy_swap;
	pad_pkg::joy_t pad_joy_a;
	pad_pkg::joy_t pad_joy_b;
	logic          present_a;
	logic          present_b;
	logic          combo_a;
	logic          combo_b;

	pad_config u_pad_config (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_data     (cfg_data),
		.llapi_enable (llapi_enable),
		.joy_swap     (joy_swap)
	);

	//======================================
	// LLAPI ports, one per pad
	//======================================

	llapi_port u_port_a (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.buttons    (llapi_buttons_a),
		.pad_type   (llapi_type_a),
		.link       (llapi_link_a),
		.pad_joy    (pad_joy_a),
		.present    (present_a),
		.menu_combo (combo_a)
	);

	llapi_port u_port_b (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.buttons    (llapi_buttons_b),
		.pad_type   (llapi_type_b),
		.link       (llapi_link_b),
		.pad_joy    (pad_joy_b),
		.present    (present_b),
		.menu_combo (combo_b)
	);

	slot_allocator u_slot_allocator (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.llapi_enable (llapi_enable),
		.joy_swap     (joy_swap),
		.joy_a        (pad_joy_a),
		.present_a    (present_a),
		.combo_a      (combo_a),
		.joy_b        (pad_joy_b),
		.present_b    (present_b),
		.combo_b      (combo_b),
		.usb_joy0     (usb_joy0),
		.usb_joy1     (usb_joy1),
		.usb_joy2     (usb_joy2),
		.usb_joy3     (usb_joy3),
		.usb_joy4     (usb_joy4),
		.joy0         (joy0),
		.joy1         (joy1),
		.joy2         (joy2),
		.joy3         (joy3),
		.joy4         (joy4),
		.osd_req      (osd_req)
	);

endmodule

/* tests/pad_router_props.sv */
//======================================
// Slot allocator properties
// Reset values, USB pass-through and
// menu request timing
//======================================

module slot_allocator_props (
	input logic          clk_sys,
	input logic          reset,
	input logic          llapi_enable,
	input logic          joy_swap,
	input logic          combo_a,
	input logic          combo_b,
	input pad_pkg::joy_t usb_joy0,
	input pad_pkg::joy_t usb_joy1,
	input pad_pkg::joy_t usb_joy2,
	input pad_pkg::joy_t usb_joy3,
	input pad_pkg::joy_t usb_joy4,
	input pad_pkg::joy_t joy0,
	input pad_pkg::joy_t joy1,
	input pad_pkg::joy_t joy2,
	input pad_pkg::joy_t joy3,
	input pad_pkg::joy_t joy4,
	input logic          osd_req
);

	reset_clears: assert property (@(posedge clk_sys)
		reset |=> (osd_req == 1'b0) && (joy0 == '0) && (joy1 == '0) &&
			(joy2 == '0) && (joy3 == '0) && (joy4 == '0))
		else $error("outputs not cleared by reset");

	// LLAPI off, every slot follows its USB word
	usb_only: assert property (@(posedge clk_sys) disable iff (reset)
		!llapi_enable |=>
			(joy0 == ($past(joy_swap) ? $past(usb_joy1) : $past(usb_joy0))) &&
			(joy1 == ($past(joy_swap) ? $past(usb_joy0) : $past(usb_joy1))) &&
			(joy2 == $past(usb_joy2)) && (joy3 == $past(usb_joy3)) &&
			(joy4 == $past(usb_joy4)))
		else $error("USB words not passed to the slots");

	osd_follows_combo: assert property (@(posedge clk_sys) disable iff (reset)
		1'b1 |=> (osd_req == ($past(combo_a) | $past(combo_b))))
		else $error("menu request does not follow the combos");

endmodule

bind slot_allocator slot_allocator_props u_slot_allocator_props (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.llapi_enable (llapi_enable),
	.joy_swap     (joy_swap),
	.combo_a      (combo_a),
	.combo_b      (combo_b),
	.usb_joy0     (usb_joy0),
	.usb_joy1     (usb_joy1),
	.usb_joy2     (usb_joy2),
	.usb_joy3     (usb_joy3),
	.usb_joy4     (usb_joy4),
	.joy0         (joy0),
	.joy1         (joy1),
	.joy2         (joy2),
	.joy3         (joy3),
	.joy4         (joy4),
	.osd_req      (osd_req)
);

/* tests/pad_router_tb.sv */
//======================================
// Controller router testbench
// Directed tests of slot allocation,
// remapping, swap and menu request
//======================================

module pad_router_tb;

	localparam int CLK_PERIOD  = 10;
	localparam int NUM_TESTS   = 6;
	localparam int TEST_CYCLES = 60;

	logic                           clk_sys;
	logic                           reset;
	logic                           cfg_wr;
	logic [cfg_pkg::CFG_ADDR_W-1:0] cfg_addr;
	logic [cfg_pkg::CFG_DATA_W-1:0] cfg_data;
	pad_pkg::ll_btn_t               btn_a;
	pad_pkg::ll_btn_t               btn_b;
	pad_pkg::ll_type_t              type_a;
	pad_pkg::ll_type_t              type_b;
	logic                           link_a;
	logic                           link_b;
	pad_pkg::joy_t                  usb0;
	pad_pkg::joy_t                  usb1;
	pad_pkg::joy_t                  usb2;
	pad_pkg::joy_t                  usb3;
	pad_pkg::joy_t                  usb4;
	pad_pkg::joy_t                  joy0;
	pad_pkg::joy_t                  joy1;
	pad_pkg::joy_t                  joy2;
	pad_pkg::joy_t                  joy3;
	pad_pkg::joy_t                  joy4;
	logic                           osd_req;

	pad_router_top u_pad_router_top (
		.clk_sys (clk_sys), .reset (reset),
		.cfg_wr (cfg_wr), .cfg_addr (cfg_addr), .cfg_data (cfg_data),
		.llapi_buttons_a (btn_a), .llapi_type_a (type_a), .llapi_link_a (link_a),
		.llapi_buttons_b (btn_b), .llapi_type_b (type_b), .llapi_link_b (link_b),
		.usb_joy0 (usb0), .usb_joy1 (usb1), .usb_joy2 (usb2),
		.usb_joy3 (usb3), .usb_joy4 (usb4),
		.joy0 (joy0), .joy1 (joy1), .joy2 (joy2), .joy3 (joy3), .joy4 (joy4),
		.osd_req (osd_req)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(CLK_PERIOD * NUM_TESTS * TEST_CYCLES);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("test failed");
		$fatal(1);
	end

	//======================================
	// Helpers
	//======================================

	// Inputs change and outputs are read just after the rising edge
	task automatic step(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR @%0t: %s expected %h got %h", $time, what, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_slots(input string what, input pad_pkg::joy_t e0, e1, e2, e3, e4);
		check({what, " joy0"}, e0, joy0);
		check({what, " joy1"}, e1, joy1);
		check({what, " joy2"}, e2, joy2);
		check({what, " joy3"}, e3, joy3);
		check({what, " joy4"}, e4, joy4);
	endtask

	// Console order start select R L Y X B A up down left right
	function automatic pad_pkg::joy_t expect_map(input pad_pkg::ll_btn_t b, input logic saturn);
		logic sel;
		logic r;
		logic l;
		sel = saturn ? b[pad_pkg::LL_B_L] : b[pad_pkg::LL_B_SEL];
		r   = saturn ? (b[pad_pkg::LL_B_R2] | b[pad_pkg::LL_B_R]) : b[pad_pkg::LL_B_R];
		l   = saturn ? b[pad_pkg::LL_B_L2] : b[pad_pkg::LL_B_L];
		return {b[pad_pkg::LL_B_START], sel, r, l, b[pad_pkg::LL_B_Y], b[pad_pkg::LL_B_X],
			b[pad_pkg::LL_B_A0], b[pad_pkg::LL_B_A1], b[pad_pkg::LL_B_UP],
			b[pad_pkg::LL_B_DOWN], b[pad_pkg::LL_B_LEFT], b[pad_pkg::LL_B_RIGHT]};
	endfunction

	task automatic apply_reset();
		{cfg_wr, cfg_addr, cfg_data} = '0;
		{btn_a, btn_b, type_a, type_b, link_a, link_b} = '0;
		{usb0, usb1, usb2, usb3, usb4} = '0;
		reset = 1'b1;
		step(10);
		reset = 1'b0;
	endtask

	// Returns once the new value has reached the joy outputs
	task automatic cfg_write(input logic [cfg_pkg::CFG_ADDR_W-1:0] addr,
		input logic [cfg_pkg::CFG_DATA_W-1:0] data);
		cfg_addr = addr;
		cfg_data = data;
		cfg_wr   = 1'b1;
		step(1);
		cfg_wr   = 1'b0;
		step(1);
	endtask

	task automatic drive_usb_random();
		usb0 = pad_pkg::joy_t'($urandom);
		usb1 = pad_pkg::joy_t'($urandom);
		usb2 = pad_pkg::joy_t'($urandom);
		usb3 = pad_pkg::joy_t'($urandom);
		usb4 = pad_pkg::joy_t'($urandom);
	endtask

	//======================================
	// Tests
	//======================================

	task automatic usb_passthrough();
		apply_reset();
		drive_usb_random();
		{link_a, type_a, btn_a} = {1'b1, 8'd1, 32'($urandom)};
		check_slots("after reset", '0, '0, '0, '0, '0);
		step(1);
		check_slots("usb only", usb0, usb1, usb2, usb3, usb4);
		step(2);
		check_slots("pad ignored", usb0, usb1, usb2, usb3, usb4);
	endtask

	task automatic button_mapping(input logic [7:0] ta, tb, input logic sat_a, sat_b);
		apply_reset();
		cfg_write(cfg_pkg::ADDR_LLAPI_EN, 8'h01);
		{link_a, link_b, type_a, type_b} = {2'b11, ta, tb};
		repeat (4) begin
			btn_a = $urandom;
			btn_b = $urandom;
			drive_usb_random();
			step(2);
			check_slots("two pads", expect_map(btn_a, sat_a), expect_map(btn_b, sat_b),
				usb0, usb1, usb2);
		end
	endtask

	task automatic sticky_presence();
		apply_reset();
		cfg_write(cfg_pkg::ADDR_LLAPI_EN, 8'h01);
		{link_a, type_a, btn_a} = {1'b1, 8'd1, 32'($urandom)};
		{link_b, type_b, btn_b} = {1'b1, 8'd0, 32'd0};
		drive_usb_random();
		step(2);
		check_slots("pad b absent", expect_map(btn_a, 1'b0), usb0, usb1, usb2, usb3);
		btn_b = 32'($urandom) | 32'h1;
		step(1);
		btn_b = '0;
		step(2);
		check_slots("pad b pressed", expect_map(btn_a, 1'b0), '0, usb0, usb1, usb2);
		step(3);
		check_slots("pad b sticky", expect_map(btn_a, 1'b0), '0, usb0, usb1, usb2);
	endtask

	task automatic player_swap();
		apply_reset();
		cfg_write(cfg_pkg::ADDR_LLAPI_EN, 8'h01);
		{link_a, link_b, type_a, type_b} = {2'b11, 8'd1, 8'd1};
		btn_a = $urandom;
		btn_b = $urandom;
		drive_usb_random();
		cfg_write(cfg_pkg::ADDR_SWAP, 8'h01);
		check_slots("swapped", expect_map(btn_b, 1'b0), expect_map(btn_a, 1'b0),
			usb0, usb1, usb2);
		// Clearing data would undo the enable or the swap if it leaked through
		cfg_write(4'd5, 8'h00);
		check_slots("unused addr", expect_map(btn_b, 1'b0), expect_map(btn_a, 1'b0),
			usb0, usb1, usb2);
	endtask

	// LLAPI stays disabled and pad B unlinked
	task automatic osd_combo();
		apply_reset();
		btn_b = '0;
		btn_b[pad_pkg::LL_B_DOWN]  = 1'b1;
		btn_b[pad_pkg::LL_B_START] = 1'b1;
		btn_b[pad_pkg::LL_B_A0]    = 1'b1;
		step(1);
		check("osd one cycle", 1'b0, osd_req);
		step(1);
		check("osd raised", 1'b1, osd_req);
		btn_b = '0;
		step(1);
		check("osd held", 1'b1, osd_req);
		step(1);
		check("osd dropped", 1'b0, osd_req);
	endtask

	initial begin
		void'($urandom(32'h24d8));
		usb_passthrough();
		button_mapping(8'd1, 8'd1, 1'b0, 1'b0);
		button_mapping(pad_pkg::LL_TYPE_SATURN, pad_pkg::LL_TYPE_SATURN_ALT, 1'b1, 1'b1);
		sticky_presence();
		player_swap();
		osd_combo();
		$display("test passed");
		$finish;
	end

endmodule

/* pad_router_top.f */
verilog/pad_pkg.sv
verilog/cfg_pkg.sv
verilog/pad_config.sv
verilog/llapi_port.sv
verilog/slot_allocator.sv
verilog/pad_router_top.sv
tests/pad_router_props.sv
tests/pad_router_tb.sv

/* Bender.yml */
package:
  name: pad_router

sources:
  - files:
      - verilog/pad_pkg.sv
      - verilog/cfg_pkg.sv
      - verilog/pad_config.sv
      - verilog/llapi_port.sv
      - verilog/slot_allocator.sv
      - verilog/pad_router_top.sv
  - target: test
    files:
      - tests/pad_router_props.sv
      - tests/pad_router_tb.sv
